//--- filelist.f
+incdir+include
rtl/core_pkg.sv
rtl/reg_file.sv
rtl/inst_decode.sv
rtl/int_execute.sv
rtl/result_commit.sv
rtl/mini_mips.sv
sim/tb_mini_mips.sv

//--- Bender.yml
package:
  name: mini_mips

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/core_pkg.sv
      - rtl/reg_file.sv
      - rtl/inst_decode.sv
      - rtl/int_execute.sv
      - rtl/result_commit.sv
      - rtl/mini_mips.sv

  - target: simulation
    include_dirs:
      - include
    files:
      - sim/tb_mini_mips.sv

//--- sim/tb_mini_mips.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module tb_mini_mips
	import core_pkg::*;
();

localparam int NUM_WORDS = 400;
// words, about a quarter more for idle cycles, then margin for reset and drain
localparam int MAX_CYCLES = NUM_WORDS + NUM_WORDS / 4 + 100;

localparam logic [5:0] R_FUNCTS [8] = '{`CORE_FN_ADDU, `CORE_FN_SUBU, `CORE_FN_AND,
	`CORE_FN_OR, `CORE_FN_XOR, `CORE_FN_SLT, `CORE_FN_SLL, `CORE_FN_SRL};
localparam logic [5:0] I_OPS [4] = '{`CORE_OP_ADDIU, `CORE_OP_ANDI, `CORE_OP_ORI,
	`CORE_OP_LUI};

logic    clk;
logic    reset;
logic    inst_valid;
word_t   inst;
commit_t commit;
word_t   retire_count;

word_t   model_regs [`CORE_NREGS];
commit_t exp_q [$];
int      due_q [$];
int      cycle = 0;
int      commits_seen = 0;
int      words_sent = 0;

mini_mips u_dut(
	.clk,
	.reset,
	.inst_valid,
	.inst,
	.commit,
	.retire_count
);

initial
begin
	clk = 1'b0;
	forever #5 clk = ~clk;
end

always @(posedge clk)
begin
	cycle <= cycle + 1;
	if (cycle == MAX_CYCLES)
	begin
		$display("timeout: the pipeline did not finish within %0d cycles", MAX_CYCLES);
		$display("Testbench failed");
		$fatal(1);
	end
end

task automatic check_commit(input string name, input commit_t exp, input commit_t act);
	logic bad;
	// payload is only meaningful while valid is high
	bad = exp.valid ? (act !== exp) : (act.valid !== 1'b0);
	if (bad)
	begin
		$display("ERROR at %0t: %s expected valid=%b illegal=%b rd=%0d data=%h,",
			$time, name, exp.valid, exp.illegal, exp.rd, exp.data);
		$display("  got valid=%b illegal=%b rd=%0d data=%h",
			act.valid, act.illegal, act.rd, act.data);
		$display("Testbench failed");
		$fatal(1);
	end
endtask

task automatic check_count(input string name, input word_t exp, input word_t act);
	if (act !== exp)
	begin
		$display("ERROR at %0t: %s expected %0d, got %0d", $time, name, exp, act);
		$display("Testbench failed");
		$fatal(1);
	end
endtask

// mostly r0..r3 so that neighbours depend on each other
function automatic reg_addr_t pick_reg();
	if ($urandom % 4 != 0)
		return reg_addr_t'($urandom % 4);
	return reg_addr_t'($urandom);
endfunction

function automatic inst_t random_word();
	inst_t      w;
	logic [5:0] code;
	w.r.rs = pick_reg();
	w.r.rt = pick_reg();
	w.r.rd = pick_reg();
	w.r.shamt = 5'($urandom);
	w.r.funct = R_FUNCTS[$urandom % 8];
	if ($urandom % 100 < 5)
	begin
		if ($urandom % 2)
		begin
			w.r.opcode = `CORE_OP_SPECIAL;
			do
				code = 6'($urandom);
			while (code inside {R_FUNCTS});
			w.r.funct = code;
		end
		else
		begin
			do
				code = 6'($urandom);
			while (code inside {`CORE_OP_SPECIAL, I_OPS});
			w.i.opcode = code;
		end
	end
	else if ($urandom % 12 < 8)
		w.r.opcode = `CORE_OP_SPECIAL;
	else
	begin
		w.i.imm = 16'($urandom);
		w.i.opcode = I_OPS[$urandom % 4];
	end
	return w;
endfunction

// reference behavior of one instruction against the model registers
function automatic commit_t model_exec(input inst_t w);
	commit_t     c;
	word_t       a;
	word_t       b;
	logic [15:0] imm;
	c = '0;
	c.valid = 1'b1;
	a = model_regs[w.r.rs];
	b = model_regs[w.r.rt];
	imm = w.i.imm;
	c.rd = w.i.rt;
	case (w.r.opcode)
	`CORE_OP_SPECIAL:
	begin
		c.rd = w.r.rd;
		case (w.r.funct)
		`CORE_FN_ADDU: c.data = a + b;
		`CORE_FN_SUBU: c.data = a - b;
		`CORE_FN_AND:  c.data = a & b;
		`CORE_FN_OR:   c.data = a | b;
		`CORE_FN_XOR:  c.data = a ^ b;
		`CORE_FN_SLT:  c.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		`CORE_FN_SLL:  c.data = b << w.r.shamt;
		`CORE_FN_SRL:  c.data = b >> w.r.shamt;
		default:       c.illegal = 1'b1;
		endcase
	end
	`CORE_OP_ADDIU: c.data = a + {{16{imm[15]}}, imm};
	`CORE_OP_ANDI:  c.data = a & {16'h0000, imm};
	`CORE_OP_ORI:   c.data = a | {16'h0000, imm};
	`CORE_OP_LUI:   c.data = {imm, 16'h0000};
	default:        c.illegal = 1'b1;
	endcase
	if (c.illegal)
	begin
		c.rd = '0;
		c.data = '0;
	end
	return c;
endfunction

task automatic observe_outputs();
	commit_t exp;
	exp = '0;
	if (due_q.size() > 0 && due_q[0] == cycle)
	begin
		exp = exp_q.pop_front();
		void'(due_q.pop_front());
	end
	check_commit("commit", exp, commit);
	if (commit.valid)
		commits_seen++;
	check_count("retire_count", word_t'(commits_seen), retire_count);
endtask

initial
begin
	inst_t   w;
	commit_t exp;
	void'($urandom(32'h44da749a));
	reset = 1'b1;
	inst_valid = 1'b0;
	inst = '0;
	for (int i = 0; i < `CORE_NREGS; i++)
		model_regs[i] = '0;
	repeat (4) @(negedge clk);
	reset = 1'b0;
	repeat (3)
	begin
		@(negedge clk);
		observe_outputs();
	end
	while (words_sent < NUM_WORDS)
	begin
		@(negedge clk);
		observe_outputs();
		if ($urandom % 5 == 0)
		begin
			// bubble with junk on the data lines
			inst_valid = 1'b0;
			inst = $urandom;
		end
		else
		begin
			w = random_word();
			exp = model_exec(w);
			if (!exp.illegal && exp.rd != '0)
				model_regs[exp.rd] = exp.data;
			exp_q.push_back(exp);
			// taken at the next edge, on commit two edges after that
			due_q.push_back(cycle + 3);
			inst_valid = 1'b1;
			inst = w;
			words_sent++;
		end
	end
	while (exp_q.size() > 0)
	begin
		@(negedge clk);
		observe_outputs();
		inst_valid = 1'b0;
	end
	repeat (3)
	begin
		@(negedge clk);
		observe_outputs();
	end
	if (commits_seen == NUM_WORDS && retire_count == word_t'(NUM_WORDS))
	begin
		$display("Testbench passed");
		$finish;
	end
	else
	begin
		$display("commit count %0d does not match the %0d words sent", commits_seen,
			NUM_WORDS);
		$display("Testbench failed");
		$fatal(1);
	end
end

endmodule

`default_nettype wire

//--- rtl/mini_mips.sv
`timescale 1ns/1ps
`default_nettype none

module mini_mips
	import core_pkg::*;
(
	input  logic    clk,
	input  logic    reset,
	input  logic    inst_valid,
	input  word_t   inst,
	output commit_t commit,
	output word_t   retire_count
);

reg_addr_t  rs_addr, rt_addr;
word_t      rs_data, rt_data;
reg_write_t reg_wr;
dec_op_t    dec_op;
exe_res_t   ex_fwd, cm_fwd, exe_res;

reg_file u_reg_file(
	.clk,
	.reset,
	.rs_addr,
	.rt_addr,
	.rs_data,
	.rt_data,
	.reg_wr
);

inst_decode u_decode(
	.clk,
	.reset,
	.inst_valid,
	.inst,
	.rs_addr,
	.rt_addr,
	.rs_data,
	.rt_data,
	.ex_fwd,
	.cm_fwd,
	.dec_op
);

int_execute u_execute(
	.clk,
	.reset,
	.dec_op,
	.ex_fwd,
	.exe_res
);

result_commit u_commit(
	.clk,
	.reset,
	.exe_res,
	.cm_fwd,
	.commit,
	.reg_wr,
	.retire_count
);

endmodule

`default_nettype wire

//--- rtl/result_commit.sv
`timescale 1ns/1ps
`default_nettype none

module result_commit
	import core_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  exe_res_t   exe_res,
	output exe_res_t   cm_fwd,
	output commit_t    commit,
	output reg_write_t reg_wr,
	output word_t      retire_count
);

// exe_res is already registered, it holds the op two ahead of decode
assign cm_fwd = exe_res;

always_ff @(posedge clk)
begin
	if (reset)
	begin
		commit.valid <= 1'b0;
		commit.illegal <= 1'b0;
		retire_count <= '0;
	end
	else
	begin
		commit <= '{valid: exe_res.valid, illegal: exe_res.illegal,
			rd: exe_res.rd, data: exe_res.data};
		// illegal ops retire too
		if (exe_res.valid)
			retire_count <= retire_count + 1'b1;
	end
end

// register file takes it on the next edge
assign reg_wr.we = commit.valid && !commit.illegal && commit.rd != '0;
assign reg_wr.addr = commit.rd;
assign reg_wr.data = commit.data;

a_retire_step: assert property (@(posedge clk) disable iff (reset)
	commit.valid |-> retire_count == $past(retire_count) + 1);

endmodule

`default_nettype wire

//--- rtl/int_execute.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module int_execute
	import core_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  dec_op_t  dec_op,
	output exe_res_t ex_fwd,
	output exe_res_t exe_res
);

word_t result;
logic  lt;

assign lt = $signed(dec_op.opa) < $signed(dec_op.opb);

always_comb
begin
	case (dec_op.alu_op)
	ALU_ADD: result = dec_op.opa + dec_op.opb;
	ALU_SUB: result = dec_op.opa - dec_op.opb;
	ALU_AND: result = dec_op.opa & dec_op.opb;
	ALU_OR:  result = dec_op.opa | dec_op.opb;
	ALU_XOR: result = dec_op.opa ^ dec_op.opb;
	ALU_SLT: result = {{(`CORE_XLEN-1){1'b0}}, lt};
	// shifts act on rt, amount from the shamt field
	ALU_SLL: result = dec_op.opb << dec_op.shamt;
	ALU_SRL: result = dec_op.opb >> dec_op.shamt;
	ALU_LUI: result = dec_op.opb;
	default: result = '0;
	endcase
end

// result of the op in this stage, seen by decode in the same cycle
always_comb
begin
	ex_fwd.valid = dec_op.valid;
	ex_fwd.illegal = dec_op.illegal;
	ex_fwd.rd = dec_op.rd;
	ex_fwd.data = dec_op.illegal ? '0 : result;
end

always_ff @(posedge clk)
begin
	if (reset)
	begin
		exe_res.valid <= 1'b0;
		exe_res.illegal <= 1'b0;
	end
	else
	begin
		exe_res <= ex_fwd;
	end
end

endmodule

`default_nettype wire

//--- rtl/inst_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module inst_decode
	import core_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  logic      inst_valid,
	input  word_t     inst,
	output reg_addr_t rs_addr,
	output reg_addr_t rt_addr,
	input  word_t     rs_data,
	input  word_t     rt_data,
	input  exe_res_t  ex_fwd,
	input  exe_res_t  cm_fwd,
	output dec_op_t   dec_op
);

inst_t   iw;
word_t   rs_val;
word_t   rt_val;
dec_op_t dec_next;

function automatic logic fwd_hit(input exe_res_t src, input reg_addr_t addr);
	return src.valid && !src.illegal && src.rd == addr && addr != '0;
endfunction

assign iw = inst;
assign rs_addr = iw.i.rs;
assign rt_addr = iw.i.rt;

// execute result first, then the op behind it, then the register file
assign rs_val = fwd_hit(ex_fwd, rs_addr) ? ex_fwd.data :
	fwd_hit(cm_fwd, rs_addr) ? cm_fwd.data : rs_data;
assign rt_val = fwd_hit(ex_fwd, rt_addr) ? ex_fwd.data :
	fwd_hit(cm_fwd, rt_addr) ? cm_fwd.data : rt_data;

always_comb
begin
	dec_next = '0;
	dec_next.valid = inst_valid;
	dec_next.opa = rs_val;
	case (iw.r.opcode)
	`CORE_OP_SPECIAL:
	begin
		dec_next.rd = iw.r.rd;
		dec_next.opb = rt_val;
		dec_next.shamt = iw.r.shamt;
		case (iw.r.funct)
		`CORE_FN_ADDU: dec_next.alu_op = ALU_ADD;
		`CORE_FN_SUBU: dec_next.alu_op = ALU_SUB;
		`CORE_FN_AND:  dec_next.alu_op = ALU_AND;
		`CORE_FN_OR:   dec_next.alu_op = ALU_OR;
		`CORE_FN_XOR:  dec_next.alu_op = ALU_XOR;
		`CORE_FN_SLT:  dec_next.alu_op = ALU_SLT;
		`CORE_FN_SLL:  dec_next.alu_op = ALU_SLL;
		`CORE_FN_SRL:  dec_next.alu_op = ALU_SRL;
		default:       dec_next.illegal = 1'b1;
		endcase
	end
	`CORE_OP_ADDIU:
	begin
		dec_next.alu_op = ALU_ADD;
		dec_next.rd = iw.i.rt;
		dec_next.opb = {{16{iw.i.imm[15]}}, iw.i.imm};
	end
	`CORE_OP_ANDI:
	begin
		dec_next.alu_op = ALU_AND;
		dec_next.rd = iw.i.rt;
		dec_next.opb = {16'h0000, iw.i.imm};
	end
	`CORE_OP_ORI:
	begin
		dec_next.alu_op = ALU_OR;
		dec_next.rd = iw.i.rt;
		dec_next.opb = {16'h0000, iw.i.imm};
	end
	`CORE_OP_LUI:
	begin
		dec_next.alu_op = ALU_LUI;
		dec_next.rd = iw.i.rt;
		dec_next.opb = {iw.i.imm, 16'h0000};
	end
	default:
		dec_next.illegal = 1'b1;
	endcase
	// idle cycles stay clean bubbles
	dec_next.illegal = dec_next.illegal && inst_valid;
	if (dec_next.illegal)
		dec_next.rd = '0;
end

always_ff @(posedge clk)
begin
	if (reset)
	begin
		dec_op.valid <= 1'b0;
		dec_op.illegal <= 1'b0;
	end
	else
	begin
		dec_op <= dec_next;
	end
end

a_illegal_no_rd: assert property (@(posedge clk) disable iff (reset)
	dec_op.valid && dec_op.illegal |-> dec_op.rd == '0);

endmodule

`default_nettype wire

//--- rtl/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module reg_file
	import core_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  reg_addr_t  rs_addr,
	input  reg_addr_t  rt_addr,
	output word_t      rs_data,
	output word_t      rt_data,
	input  reg_write_t reg_wr
);

word_t regs [`CORE_NREGS];

always_ff @(posedge clk)
begin
	if (reset)
	begin
		for (int i = 0; i < `CORE_NREGS; i++)
			regs[i] <= '0;
	end
	else if (reg_wr.we && reg_wr.addr != '0)
	begin
		regs[reg_wr.addr] <= reg_wr.data;
	end
end

// write-through covers the op retiring this cycle
assign rs_data = (reg_wr.we && reg_wr.addr != '0 && reg_wr.addr == rs_addr) ?
	reg_wr.data : regs[rs_addr];
assign rt_data = (reg_wr.we && reg_wr.addr != '0 && reg_wr.addr == rt_addr) ?
	reg_wr.data : regs[rt_addr];

a_zero_reg: assert property (@(posedge clk) disable iff (reset)
	(rs_addr != '0 || rs_data == '0) && (rt_addr != '0 || rt_data == '0));

endmodule

`default_nettype wire

//--- rtl/core_pkg.sv
`default_nettype none

`include "core_consts.svh"

package core_pkg;

	typedef logic [`CORE_XLEN-1:0] word_t;
	typedef logic [`CORE_RADDR_W-1:0] reg_addr_t;

	typedef struct packed {
		logic [5:0] opcode;
		reg_addr_t  rs;
		reg_addr_t  rt;
		reg_addr_t  rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} inst_r_t;

	typedef struct packed {
		logic [5:0]  opcode;
		reg_addr_t   rs;
		reg_addr_t   rt;
		logic [15:0] imm;
	} inst_i_t;

	// same word, two field layouts
	typedef union packed {
		inst_r_t r;
		inst_i_t i;
	} inst_t;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLL,
		ALU_SRL,
		ALU_LUI
	} alu_op_t;

	typedef struct packed {
		logic       valid;
		logic       illegal;
		alu_op_t    alu_op;
		reg_addr_t  rd;
		word_t      opa;
		word_t      opb;
		logic [4:0] shamt;
	} dec_op_t;

	typedef struct packed {
		logic      valid;
		logic      illegal;
		reg_addr_t rd;
		word_t     data;
	} exe_res_t;

	typedef struct packed {
		logic      we;
		reg_addr_t addr;
		word_t     data;
	} reg_write_t;

	typedef struct packed {
		logic      valid;
		logic      illegal;
		reg_addr_t rd;
		word_t     data;
	} commit_t;

endpackage

`default_nettype wire

//--- include/core_consts.svh
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

`define CORE_XLEN     32
`define CORE_NREGS    32
`define CORE_RADDR_W  5

// major opcodes
`define CORE_OP_SPECIAL  6'b000000
`define CORE_OP_ADDIU    6'b001001
`define CORE_OP_ANDI     6'b001100
`define CORE_OP_ORI      6'b001101
`define CORE_OP_LUI      6'b001111

// function codes under SPECIAL
`define CORE_FN_SLL   6'b000000
`define CORE_FN_SRL   6'b000010
`define CORE_FN_ADDU  6'b100001
`define CORE_FN_SUBU  6'b100011
`define CORE_FN_AND   6'b100100
`define CORE_FN_OR    6'b100101
`define CORE_FN_XOR   6'b100110
`define CORE_FN_SLT   6'b101010

`endif
